// ==== verif/cache_bank_stimulus.txt ====
# rw(1=write) word_addr byteen write_data expected_read_data (hex)
# expected_read_data is ignored for writes
0 0a4 f 00000000 a5a500a4
0 0a5 f 00000000 a5a500a5
1 0a6 3 1234abcd 00000000
0 0a6 f 00000000 a5a5abcd
1 0a7 c deadbeef 00000000
0 0a7 f 00000000 dead00a7
0 4a4 f 00000000 a5a504a4
0 0a6 f 00000000 a5a5abcd
0 0a7 f 00000000 dead00a7
1 100 f 11111111 00000000
0 100 f 00000000 11111111
0 101 f 00000000 a5a50101
1 103 1 000000ff 00000000
0 103 f 00000000 a5a501ff
0 140 f 00000000 a5a50140
0 100 f 00000000 11111111
1 3fc f cafef00d 00000000
1 3fd 6 00aa5500 00000000
0 3fc f 00000000 cafef00d
0 3fd f 00000000 a5aa55fd
0 ffc f 00000000 a5a50ffc
0 3fd f 00000000 a5aa55fd
1 0a4 8 77000000 00000000
0 0a4 f 00000000 77a500a4
0 ffe f 00000000 a5a50ffe
0 4a5 f 00000000 a5a504a5

// ==== compile.f ====
verilog/cache_bank_pkg.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/bank_ctrl.sv
verilog/cache_bank.sv
verif/cache_bank_asserts.sv
verif/cache_bank_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_bank_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/cache_bank_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank_tb;

    localparam int OP_TIMEOUT = 64;

    logic clk;
    logic reset;
    logic core_req_valid;
    logic core_req_rw;
    cache_bank_pkg::word_addr_t   core_req_addr;
    cache_bank_pkg::byteen_t      core_req_byteen;
    cache_bank_pkg::word_t        core_req_data;
    wire                          core_req_ready;
    wire                          core_rsp_valid;
    cache_bank_pkg::word_t        core_rsp_data;
    wire                          dram_fill_req_valid;
    cache_bank_pkg::line_addr_t   dram_fill_req_addr;
    logic                         dram_fill_rsp_valid;
    cache_bank_pkg::line_t        dram_fill_rsp_data;
    wire                          dram_wb_req_valid;
    cache_bank_pkg::line_addr_t   dram_wb_req_addr;
    cache_bank_pkg::line_t        dram_wb_req_data;
    cache_bank_pkg::line_byteen_t dram_wb_req_byteen;

    cache_bank_pkg::word_t        ref_mem  [4096];
    cache_bank_pkg::line_t        dram_mem [1024];
    logic                         sh_valid [16];
    cache_bank_pkg::tag_t         sh_tag   [16];
    cache_bank_pkg::line_byteen_t sh_dirty [16];

    int fill_count = 0;
    int wb_count = 0;
    cache_bank_pkg::line_addr_t   last_fill_addr;
    cache_bank_pkg::line_addr_t   last_wb_addr;
    cache_bank_pkg::line_t        last_wb_data;
    cache_bank_pkg::line_byteen_t last_wb_byteen;
    logic [31:0] rng_state = 32'h4917_0d05;

    cache_bank i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cache_bank_pkg::line_t ref_line(input cache_bank_pkg::line_addr_t la);
        cache_bank_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = ref_mem[{la, 2'(w)}];
        end
        return l;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic compare_word(input string what, input cache_bank_pkg::word_t got,
                                input cache_bank_pkg::word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR @%0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_line(input string what, input cache_bank_pkg::line_t got,
                                input cache_bank_pkg::line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR @%0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_line_addr(input string what, input cache_bank_pkg::line_addr_t got,
                                     input cache_bank_pkg::line_addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR @%0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_byteen(input string what, input cache_bank_pkg::line_byteen_t got,
                                  input cache_bank_pkg::line_byteen_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR @%0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    // DRAM model answering fills after a random delay of 1 to 8 cycles
    initial begin : dram_model
        int delay;
        forever begin
            @(negedge clk);
            if (dram_wb_req_valid) begin
                wb_count++;
                last_wb_addr   = dram_wb_req_addr;
                last_wb_data   = dram_wb_req_data;
                last_wb_byteen = dram_wb_req_byteen;
                for (int b = 0; b < 16; b++) begin
                    if (dram_wb_req_byteen[b]) begin
                        dram_mem[dram_wb_req_addr][b*8 +: 8] = dram_wb_req_data[b*8 +: 8];
                    end
                end
            end
            if (dram_fill_req_valid) begin
                fill_count++;
                last_fill_addr = dram_fill_req_addr;
                rng_state = xorshift32(rng_state);
                delay = int'(rng_state[2:0]) + 1;
                repeat (delay) @(negedge clk);
                dram_fill_rsp_data  = dram_mem[last_fill_addr];
                dram_fill_rsp_valid = 1'b1;
                @(negedge clk);
                dram_fill_rsp_valid = 1'b0;
            end
        end
    end

    task automatic run_op(input logic rw, input cache_bank_pkg::word_addr_t addr,
                          input cache_bank_pkg::byteen_t be, input cache_bank_pkg::word_t data,
                          input cache_bank_pkg::word_t exp);
        cache_bank_pkg::set_t set;
        cache_bank_pkg::tag_t tag;
        cache_bank_pkg::line_addr_t victim;
        cache_bank_pkg::word_t rsp_word;
        logic is_hit;
        logic exp_wb;
        int fills0;
        int wbs0;
        int rsps;
        int rsp_cycle;
        int cycles;
        set    = addr[5:2];
        tag    = addr[11:6];
        is_hit = sh_valid[set] && (sh_tag[set] == tag);
        exp_wb = !is_hit && sh_valid[set] && (sh_dirty[set] != '0);
        victim = {sh_tag[set], set};
        fills0 = fill_count;
        wbs0   = wb_count;
        if (!rw) compare_word("stimulus file expected value", exp, ref_mem[addr]);
        core_req_valid  = 1'b1;
        core_req_rw     = rw;
        core_req_addr   = addr;
        core_req_byteen = be;
        core_req_data   = data;
        cycles = 0;
        rsps   = 0;
        rsp_cycle = 0;
        rsp_word  = '0;
        do begin
            @(negedge clk);
            core_req_valid = 1'b0;
            cycles++;
            if (core_rsp_valid) begin
                rsps++;
                rsp_word  = core_rsp_data;
                rsp_cycle = cycles;
            end
            if (!core_req_ready && cycles >= OP_TIMEOUT) begin
                stop_run($sformatf("Timed out waiting for core_req_ready at address %h", addr));
            end
        end while (!core_req_ready);
        if (rsps != (rw ? 0 : 1)) begin
            stop_run($sformatf("Wrong number of core responses (%0d) at address %h", rsps, addr));
        end
        if (!rw) compare_word("read data", rsp_word, exp);
        if (is_hit && (cycles != 2 || (!rw && rsp_cycle != 2))) begin
            stop_run($sformatf("Hit at address %h took %0d cycles instead of 2", addr, cycles));
        end
        if (fill_count - fills0 != (is_hit ? 0 : 1) || wb_count - wbs0 != (exp_wb ? 1 : 0)) begin
            stop_run($sformatf("Wrong number of fills or writebacks at address %h", addr));
        end
        if (!is_hit) compare_line_addr("fill address", last_fill_addr, {tag, set});
        if (exp_wb) begin
            compare_line_addr("writeback address", last_wb_addr, victim);
            compare_byteen("writeback byte enable", last_wb_byteen, sh_dirty[set]);
            compare_line("writeback data", last_wb_data, ref_line(victim));
        end
        if (!is_hit) begin
            sh_valid[set] = 1'b1;
            sh_tag[set]   = tag;
            sh_dirty[set] = '0;
        end
        if (rw) begin
            sh_dirty[set] = sh_dirty[set] | (cache_bank_pkg::line_byteen_t'(be) << (addr[1:0] * 4));
            for (int b = 0; b < 4; b++) begin
                if (be[b]) ref_mem[addr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    initial begin : main
        int fd;
        int code;
        int n_ops;
        int f_rw;
        int f_addr;
        int f_be;
        int f_data;
        int f_exp;
        string text;
        reset = 1'b1;
        core_req_valid = 1'b0;
        core_req_rw = 1'b0;
        core_req_addr = '0;
        core_req_byteen = '0;
        core_req_data = '0;
        dram_fill_rsp_valid = 1'b0;
        dram_fill_rsp_data = '0;
        n_ops = 0;
        // Memory word value is its word address xor a constant
        for (int a = 0; a < 4096; a++) begin
            ref_mem[a] = 32'(a) ^ 32'hA5A5_0000;
            dram_mem[a / 4][(a % 4) * 32 +: 32] = 32'(a) ^ 32'hA5A5_0000;
        end
        for (int s = 0; s < 16; s++) begin
            sh_valid[s] = 1'b0;
            sh_tag[s]   = '0;
            sh_dirty[s] = '0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (!core_req_ready || core_rsp_valid || dram_fill_req_valid || dram_wb_req_valid) begin
                stop_run("Bank not idle after reset");
            end
        end
        fd = $fopen("verif/cache_bank_stimulus.txt", "r");
        if (fd == 0) stop_run("Could not open the stimulus file");
        while (!$feof(fd)) begin
            code = $fgets(text, fd);
            if (code > 0 && text.len() > 1 && text.substr(0, 0) != "#") begin
                code = $sscanf(text, "%h %h %h %h %h", f_rw, f_addr, f_be, f_data, f_exp);
                if (code != 5) stop_run($sformatf("Malformed stimulus line: %s", text));
                run_op(f_rw[0], f_addr[11:0], f_be[3:0], f_data, f_exp);
                n_ops++;
            end
        end
        $fclose(fd);
        if (n_ops == 0) begin
            stop_run("The stimulus file held no operations");
        end else begin
            $display("%0d operations checked", n_ops);
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/cache_bank_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank_asserts (
    input wire clk,
    input wire reset,
    input wire core_req_ready,
    input wire core_rsp_valid,
    input wire dram_fill_req_valid,
    input wire dram_wb_req_valid
);

    rsp_single_cycle: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |=> !core_rsp_valid)
        else $error("core_rsp_valid held longer than one cycle");

    fill_single_cycle: assert property (@(posedge clk) disable iff (reset)
        dram_fill_req_valid |=> !dram_fill_req_valid)
        else $error("dram_fill_req_valid held longer than one cycle");

    wb_single_cycle: assert property (@(posedge clk) disable iff (reset)
        dram_wb_req_valid |=> !dram_wb_req_valid)
        else $error("dram_wb_req_valid held longer than one cycle");

    fill_while_busy: assert property (@(posedge clk) disable iff (reset)
        dram_fill_req_valid |-> !core_req_ready)
        else $error("fill request issued while the bank was idle");

    // A response always follows a busy cycle
    rsp_after_busy: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |-> !$past(core_req_ready))
        else $error("core response without a preceding busy cycle");

endmodule

bind cache_bank cache_bank_asserts i_asserts (
    .clk                 (clk),
    .reset               (reset),
    .core_req_ready      (core_req_ready),
    .core_rsp_valid      (core_rsp_valid),
    .dram_fill_req_valid (dram_fill_req_valid),
    .dram_wb_req_valid   (dram_wb_req_valid)
);

`default_nettype wire

// ==== verilog/cache_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_bank (
    input  wire                                clk,
    input  wire                                reset,

    input  wire                                core_req_valid,
    input  wire                                core_req_rw,
    input  wire cache_bank_pkg::word_addr_t    core_req_addr,
    input  wire cache_bank_pkg::byteen_t       core_req_byteen,
    input  wire cache_bank_pkg::word_t         core_req_data,
    output wire                                core_req_ready,

    output wire                                core_rsp_valid,
    output wire cache_bank_pkg::word_t         core_rsp_data,

    output wire                                dram_fill_req_valid,
    output wire cache_bank_pkg::line_addr_t    dram_fill_req_addr,
    input  wire                                dram_fill_rsp_valid,
    input  wire cache_bank_pkg::line_t         dram_fill_rsp_data,

    output wire                                dram_wb_req_valid,
    output wire cache_bank_pkg::line_addr_t    dram_wb_req_addr,
    output wire cache_bank_pkg::line_t         dram_wb_req_data,
    output wire cache_bank_pkg::line_byteen_t  dram_wb_req_byteen
);

    wire                                hit;
    wire cache_bank_pkg::tag_t          victim_tag;
    wire cache_bank_pkg::line_byteen_t  victim_dirty;
    wire cache_bank_pkg::line_t         read_line;
    wire cache_bank_pkg::set_t          lookup_set;
    wire cache_bank_pkg::tag_t          req_tag;
    wire                                word_write;
    wire cache_bank_pkg::wsel_t         wsel;
    wire cache_bank_pkg::byteen_t       write_byteen;
    wire cache_bank_pkg::word_t         write_word;
    wire                                fill_write;
    wire cache_bank_pkg::line_t         fill_line;

    bank_ctrl i_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .core_req_valid      (core_req_valid),
        .core_req_rw         (core_req_rw),
        .core_req_addr       (core_req_addr),
        .core_req_byteen     (core_req_byteen),
        .core_req_data       (core_req_data),
        .core_req_ready      (core_req_ready),
        .core_rsp_valid      (core_rsp_valid),
        .core_rsp_data       (core_rsp_data),
        .dram_fill_req_valid (dram_fill_req_valid),
        .dram_fill_req_addr  (dram_fill_req_addr),
        .dram_fill_rsp_valid (dram_fill_rsp_valid),
        .dram_fill_rsp_data  (dram_fill_rsp_data),
        .dram_wb_req_valid   (dram_wb_req_valid),
        .dram_wb_req_addr    (dram_wb_req_addr),
        .dram_wb_req_data    (dram_wb_req_data),
        .dram_wb_req_byteen  (dram_wb_req_byteen),
        .hit                 (hit),
        .victim_tag          (victim_tag),
        .victim_dirty        (victim_dirty),
        .read_line           (read_line),
        .lookup_set          (lookup_set),
        .req_tag             (req_tag),
        .word_write          (word_write),
        .wsel                (wsel),
        .write_byteen        (write_byteen),
        .write_word          (write_word),
        .fill_write          (fill_write),
        .fill_line           (fill_line)
    );

    tag_store i_tags (
        .clk          (clk),
        .reset        (reset),
        .lookup_set   (lookup_set),
        .req_tag      (req_tag),
        .word_write   (word_write),
        .wsel         (wsel),
        .write_byteen (write_byteen),
        .fill_write   (fill_write),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    data_store i_data (
        .clk          (clk),
        .lookup_set   (lookup_set),
        .word_write   (word_write),
        .wsel         (wsel),
        .write_byteen (write_byteen),
        .write_word   (write_word),
        .fill_write   (fill_write),
        .fill_line    (fill_line),
        .read_line    (read_line)
    );

endmodule

`default_nettype wire

// ==== verilog/bank_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_ctrl (
    input  wire                                clk,
    input  wire                                reset,

    // Core request and response
    input  wire                                core_req_valid,
    input  wire                                core_req_rw,
    input  wire cache_bank_pkg::word_addr_t    core_req_addr,
    input  wire cache_bank_pkg::byteen_t       core_req_byteen,
    input  wire cache_bank_pkg::word_t         core_req_data,
    output logic                               core_req_ready,
    output logic                               core_rsp_valid,
    output cache_bank_pkg::word_t              core_rsp_data,

    // DRAM fill
    output logic                               dram_fill_req_valid,
    output cache_bank_pkg::line_addr_t         dram_fill_req_addr,
    input  wire                                dram_fill_rsp_valid,
    input  wire cache_bank_pkg::line_t         dram_fill_rsp_data,

    // DRAM writeback
    output logic                               dram_wb_req_valid,
    output cache_bank_pkg::line_addr_t         dram_wb_req_addr,
    output cache_bank_pkg::line_t              dram_wb_req_data,
    output cache_bank_pkg::line_byteen_t       dram_wb_req_byteen,

    // Tag and data stores
    input  wire                                hit,
    input  wire cache_bank_pkg::tag_t          victim_tag,
    input  wire cache_bank_pkg::line_byteen_t  victim_dirty,
    input  wire cache_bank_pkg::line_t         read_line,
    output cache_bank_pkg::set_t               lookup_set,
    output cache_bank_pkg::tag_t               req_tag,
    output logic                               word_write,
    output cache_bank_pkg::wsel_t              wsel,
    output cache_bank_pkg::byteen_t            write_byteen,
    output cache_bank_pkg::word_t              write_word,
    output logic                               fill_write,
    output cache_bank_pkg::line_t              fill_line
);

    cache_bank_pkg::ctrl_state_t state;
    cache_bank_pkg::ctrl_state_t state_next;

    logic                        req_rw;
    cache_bank_pkg::word_addr_t  req_addr;
    cache_bank_pkg::byteen_t     req_byteen;
    cache_bank_pkg::word_t       req_data;

    logic                        access;
    logic                        access_hit;

    // LOOKUP and REPLAY both probe the arrays
    assign access     = (state == cache_bank_pkg::LOOKUP) || (state == cache_bank_pkg::REPLAY);
    assign access_hit = access && hit;

    always_comb begin
        state_next = state;
        case (state)
            cache_bank_pkg::IDLE: begin
                if (core_req_valid) begin
                    state_next = cache_bank_pkg::LOOKUP;
                end
            end
            cache_bank_pkg::LOOKUP, cache_bank_pkg::REPLAY: begin
                if (hit) begin
                    state_next = cache_bank_pkg::IDLE;
                end else if (|victim_dirty) begin
                    state_next = cache_bank_pkg::WRITEBACK;
                end else begin
                    state_next = cache_bank_pkg::FILL_REQ;
                end
            end
            cache_bank_pkg::WRITEBACK: state_next = cache_bank_pkg::FILL_REQ;
            cache_bank_pkg::FILL_REQ:  state_next = cache_bank_pkg::FILL_WAIT;
            cache_bank_pkg::FILL_WAIT: begin
                if (dram_fill_rsp_valid) begin
                    state_next = cache_bank_pkg::REPLAY;
                end
            end
            default: state_next = cache_bank_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_bank_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Held until the request retires
    always_ff @(posedge clk) begin
        if (core_req_ready && core_req_valid) begin
            req_rw     <= core_req_rw;
            req_addr   <= core_req_addr;
            req_byteen <= core_req_byteen;
            req_data   <= core_req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            core_rsp_valid <= 1'b0;
        end else begin
            core_rsp_valid <= access_hit && !req_rw;
        end
    end

    always_ff @(posedge clk) begin
        if (access_hit && !req_rw) begin
            core_rsp_data <= read_line[wsel * cache_bank_pkg::WORD_BYTES * 8
                                       +: cache_bank_pkg::WORD_BYTES * 8];
        end
    end

    assign core_req_ready = (state == cache_bank_pkg::IDLE);

    // Request address fields
    assign wsel       = req_addr[cache_bank_pkg::WSEL_BITS-1:0];
    assign lookup_set = req_addr[cache_bank_pkg::WSEL_BITS +: cache_bank_pkg::SET_BITS];
    assign req_tag    = req_addr[cache_bank_pkg::WORD_ADDR_BITS-1 -: cache_bank_pkg::TAG_BITS];

    assign word_write   = access_hit && req_rw;
    assign write_byteen = req_byteen;
    assign write_word   = req_data;

    assign fill_write = (state == cache_bank_pkg::FILL_WAIT) && dram_fill_rsp_valid;
    assign fill_line  = dram_fill_rsp_data;

    assign dram_fill_req_valid = (state == cache_bank_pkg::FILL_REQ);
    assign dram_fill_req_addr  = {req_tag, lookup_set};

    // Victim line stays untouched until the fill lands
    assign dram_wb_req_valid  = (state == cache_bank_pkg::WRITEBACK);
    assign dram_wb_req_addr   = {victim_tag, lookup_set};
    assign dram_wb_req_data   = read_line;
    assign dram_wb_req_byteen = victim_dirty;

endmodule

`default_nettype wire

// ==== verilog/data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  wire                                clk,

    input  wire cache_bank_pkg::set_t          lookup_set,

    input  wire                                word_write,
    input  wire cache_bank_pkg::wsel_t         wsel,
    input  wire cache_bank_pkg::byteen_t       write_byteen,
    input  wire cache_bank_pkg::word_t         write_word,

    input  wire                                fill_write,
    input  wire cache_bank_pkg::line_t         fill_line,

    output cache_bank_pkg::line_t              read_line
);

    cache_bank_pkg::line_t lines [cache_bank_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (fill_write) begin
            lines[lookup_set] <= fill_line;
        end else if (word_write) begin
            // Only the enabled bytes of the selected word change
            for (int b = 0; b < cache_bank_pkg::WORD_BYTES; b++) begin
                if (write_byteen[b]) begin
                    lines[lookup_set][(wsel * cache_bank_pkg::WORD_BYTES + b) * 8 +: 8]
                        <= write_word[b * 8 +: 8];
                end
            end
        end
    end

    assign read_line = lines[lookup_set];

endmodule

`default_nettype wire

// ==== verilog/tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input  wire                                clk,
    input  wire                                reset,

    input  wire cache_bank_pkg::set_t          lookup_set,
    input  wire cache_bank_pkg::tag_t          req_tag,

    input  wire                                word_write,
    input  wire cache_bank_pkg::wsel_t         wsel,
    input  wire cache_bank_pkg::byteen_t       write_byteen,
    input  wire                                fill_write,

    output logic                               hit,
    output cache_bank_pkg::tag_t               victim_tag,
    output cache_bank_pkg::line_byteen_t       victim_dirty
);

    logic [cache_bank_pkg::NUM_SETS-1:0] valid_q;
    cache_bank_pkg::tag_t                tag_q   [cache_bank_pkg::NUM_SETS];
    cache_bank_pkg::line_byteen_t        dirty_q [cache_bank_pkg::NUM_SETS];

    cache_bank_pkg::line_byteen_t        write_mask;

    // Word byte enables moved to their place in the line
    assign write_mask = cache_bank_pkg::line_byteen_t'(write_byteen)
                        << (wsel * cache_bank_pkg::WORD_BYTES);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill_write) begin
            valid_q[lookup_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_q[lookup_set]   <= req_tag;
            dirty_q[lookup_set] <= '0;
        end else if (word_write) begin
            dirty_q[lookup_set] <= dirty_q[lookup_set] | write_mask;
        end
    end

    assign hit        = valid_q[lookup_set] && (tag_q[lookup_set] == req_tag);
    assign victim_tag = tag_q[lookup_set];

    // An invalid line has nothing to write back
    assign victim_dirty = valid_q[lookup_set] ? dirty_q[lookup_set] : '0;

endmodule

`default_nettype wire

// ==== verilog/cache_bank_pkg.sv ====
`default_nettype none

package cache_bank_pkg;

    // Bank geometry
    localparam int WORD_BYTES = 4;
    localparam int LINE_WORDS = 4;
    localparam int LINE_BYTES = WORD_BYTES * LINE_WORDS;
    localparam int NUM_SETS   = 16;

    // Address field widths
    localparam int WSEL_BITS      = $clog2(LINE_WORDS);
    localparam int SET_BITS       = $clog2(NUM_SETS);
    localparam int TAG_BITS       = 6;
    localparam int LINE_ADDR_BITS = TAG_BITS + SET_BITS;
    localparam int WORD_ADDR_BITS = LINE_ADDR_BITS + WSEL_BITS;

    // Data widths
    typedef logic [WORD_BYTES*8-1:0] word_t;
    typedef logic [WORD_BYTES-1:0]   byteen_t;
    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [LINE_BYTES-1:0]   line_byteen_t;

    // Word address is {tag, set, wsel}
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [SET_BITS-1:0]       set_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [WSEL_BITS-1:0]      wsel_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WRITEBACK = 3'd2,
        FILL_REQ  = 3'd3,
        FILL_WAIT = 3'd4,
        REPLAY    = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire
